// File: filelist.f
+incdir+common
common/rp_pkg.sv
adc/adc_capture.sv
hk/hk_exp_sync.sv
hk/hk_idly.sv
hk/hk_regs.sv
verilog/rp_top.sv
dv/tb_rp_top.sv

// File: Makefile
# Verilator build and run for the rp_top testbench

VERILATOR ?= verilator
TOP       := tb_rp_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_rp_top.sv
// testbench for rp_top, apb register traffic, adc path and tap counters checked by assertions
`timescale 1ns/10ps
`include "rp_cfg.svh"

module tb_rp_top;

  import rp_pkg::*;

  localparam int SEED       = 60;
  localparam int RST_CYCLES = 16;
  localparam int ADC_PAIRS  = 150;   // per swap setting
  localparam int REG_ROUNDS = 16;
  localparam int EXP_ROUNDS = 16;
  localparam int TAP_STEPS  = 96;
  localparam int NL         = 2 * `RP_ADC_LANES;
  localparam int EB         = `RP_EXP_BITS;
  // rough budget per phase, one apb transfer is three cycles plus an idle one
  localparam int TEST_CYCLES = RST_CYCLES + 2 * ADC_PAIRS + 40 * REG_ROUNDS
                               + 12 * EXP_ROUNDS + 8 * TAP_STEPS + 60;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  logic                    adc_clk;
  logic                    rst_n_i;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  adc_raw_t                adc_dat_a, adc_dat_b;
  adc_dat_t                adc_ch1, adc_ch2;
  exp_bank_t               exp_p_in, exp_n_in;   // pins, async to the design
  exp_ctrl_t               exp_p_out, exp_n_out;
  logic [`RP_LED_BITS-1:0] led;

  // reference model, steps on the edge that closes a write
  logic                    swap_m;
  logic [`RP_LED_BITS-1:0] led_m;
  exp_ctrl_t               exp_p_m, exp_n_m;
  idly_cnt_t [NL-1:0]      idly_m;          // lanes 0..6 ch a, 7..13 ch b
  logic                    err_exp;         // pslverr wanted in this access
  logic                    rd_chk;          // prdata compared in this access
  logic [`RP_APB_DW-1:0]   rd_exp;
  adc_raw_t                a_d1, a_d2, b_d1, b_d2;   // two cycle latency
  logic                    swap_d1;
  adc_dat_t                exp_ch1, exp_ch2;
  logic                    acc;

  rp_top rp_top_i (
    .adc_clk     (adc_clk  ),
    .rst_n_i     (rst_n_i  ),
    .apb_req_i   (apb_req  ),
    .apb_rsp_o   (apb_rsp  ),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .adc_ch1_o   (adc_ch1  ),
    .adc_ch2_o   (adc_ch2  ),
    .exp_p_i     (exp_p_in ),
    .exp_n_i     (exp_n_in ),
    .exp_p_o     (exp_p_out),
    .exp_n_o     (exp_n_out),
    .led_o       (led      )
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;   // 100 MHz
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic adc_dat_t top_bits(input adc_raw_t w);
    return w[`RP_ADC_RAW_BITS-1 -: `RP_ADC_DATA_BITS];   // lsbs dropped
  endfunction

  always @(posedge adc_clk)
  begin
    a_d1    <= adc_dat_a;
    a_d2    <= a_d1;
    b_d1    <= adc_dat_b;
    b_d2    <= b_d1;
    swap_d1 <= swap_m;   // order picked when the pair enters stage two
  end

  assign exp_ch1 = swap_d1 ? top_bits(b_d2) : top_bits(a_d2);
  assign exp_ch2 = swap_d1 ? top_bits(a_d2) : top_bits(b_d2);
  assign acc     = apb_req.psel && apb_req.penable;

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      `RP_ADDR_ID:        v = `RP_BLOCK_ID;
      `RP_ADDR_CFG:       v[0] = swap_m;
      `RP_ADDR_EXP_P_DIR: v[EB-1:0] = exp_p_m.oe;
      `RP_ADDR_EXP_N_DIR: v[EB-1:0] = exp_n_m.oe;
      `RP_ADDR_EXP_P_OUT: v[EB-1:0] = exp_p_m.dat;
      `RP_ADDR_EXP_N_OUT: v[EB-1:0] = exp_n_m.dat;
      `RP_ADDR_EXP_P_IN:  v[EB-1:0] = exp_p_in;   // held long enough to settle
      `RP_ADDR_EXP_N_IN:  v[EB-1:0] = exp_n_in;
      `RP_ADDR_LED:       v[`RP_LED_BITS-1:0] = led_m;
      `RP_ADDR_IDLY_CNT:
      begin
        v[4:0]  = idly_m[0];               // lane 0 ch a
        v[12:8] = idly_m[`RP_ADC_LANES];   // lane 0 ch b
      end
      default:            v = '0;          // idly_ctrl reads as 0
    endcase
    return v;
  endfunction

  task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
    idly_cnt_t [NL-1:0] next;
    next = idly_m;
    case (addr)
      `RP_ADDR_CFG:       swap_m      <= data[0];
      `RP_ADDR_EXP_P_DIR: exp_p_m.oe  <= data[EB-1:0];
      `RP_ADDR_EXP_N_DIR: exp_n_m.oe  <= data[EB-1:0];
      `RP_ADDR_EXP_P_OUT: exp_p_m.dat <= data[EB-1:0];
      `RP_ADDR_EXP_N_OUT: exp_n_m.dat <= data[EB-1:0];
      `RP_ADDR_LED:       led_m       <= data[`RP_LED_BITS-1:0];
      `RP_ADDR_IDLY_CTRL:
      begin
        // load wins, then up or down with wrap at 5 bits
        for (int l = 0; l < NL; l++)
          if (data[l])
            next[l] = data[17] ? idly_cnt_t'(0) :
                      data[16] ? idly_m[l] + idly_cnt_t'(1) : idly_m[l] - idly_cnt_t'(1);
        idly_m <= next;
      end
      default:            ;
    endcase
  endtask

  //////////////////////////////
  // apb requester
  //////////////////////////////

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
    @(posedge adc_clk);
    apb_req.paddr   <= addr;   // setup
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.pwdata  <= data;
    err_exp         <= err;
    rd_chk          <= 1'b0;
    @(posedge adc_clk);
    apb_req.penable <= 1'b1;   // access, zero wait
    @(posedge adc_clk);
    apb_req <= '0;
    if (!err)
      apply_write(addr, data);   // same edge as the dut register
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic err);
    @(posedge adc_clk);
    apb_req.paddr   <= addr;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.pwdata  <= '0;
    err_exp         <= err;
    rd_chk          <= !err;
    rd_exp          <= expected_read(addr);
    @(posedge adc_clk);
    apb_req.penable <= 1'b1;
    @(posedge adc_clk);
    apb_req <= '0;
    rd_chk  <= 1'b0;
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Mismatch %s: got 0x%0h, expected 0x%0h", sig, got, want);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s check failed", sig);
  endtask

  a_ch1: assert property (@(posedge adc_clk) disable iff (!rst_n_i) adc_ch1 == exp_ch1)
    else report_mismatch("adc_ch1_o", 32'($sampled(adc_ch1)), 32'($sampled(exp_ch1)));
  a_ch2: assert property (@(posedge adc_clk) disable iff (!rst_n_i) adc_ch2 == exp_ch2)
    else report_mismatch("adc_ch2_o", 32'($sampled(adc_ch2)), 32'($sampled(exp_ch2)));
  a_led: assert property (@(posedge adc_clk) disable iff (!rst_n_i) led == led_m)
    else report_mismatch("led_o", 32'($sampled(led)), 32'($sampled(led_m)));
  a_exp_p: assert property (@(posedge adc_clk) disable iff (!rst_n_i) exp_p_out == exp_p_m)
    else report_mismatch("exp_p_o", 32'($sampled(exp_p_out)), 32'($sampled(exp_p_m)));
  a_exp_n: assert property (@(posedge adc_clk) disable iff (!rst_n_i) exp_n_out == exp_n_m)
    else report_mismatch("exp_n_o", 32'($sampled(exp_n_out)), 32'($sampled(exp_n_m)));
  a_ready: assert property (@(posedge adc_clk) disable iff (!rst_n_i) acc |-> apb_rsp.pready)
    else report_mismatch("pready", 32'($sampled(apb_rsp.pready)), 32'h1);
  a_err: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
                          acc |-> (apb_rsp.pslverr == err_exp))
    else report_mismatch("pslverr", 32'($sampled(apb_rsp.pslverr)), 32'($sampled(err_exp)));
  a_rdata: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
                            (acc && rd_chk) |-> (apb_rsp.prdata == rd_exp))
    else report_mismatch("prdata", $sampled(apb_rsp.prdata), $sampled(rd_exp));

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk);
    $display("Timeout, run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    logic [7:0]  rw_addr [5];
    logic [13:0] mask;
    logic [31:0] v;
    rw_addr   = '{`RP_ADDR_LED, `RP_ADDR_EXP_P_DIR, `RP_ADDR_EXP_N_DIR,
                  `RP_ADDR_EXP_P_OUT, `RP_ADDR_EXP_N_OUT};
    rst_n_i   <= 1'b0;
    apb_req   <= '0;
    adc_dat_a <= '0;
    adc_dat_b <= '0;
    exp_p_in  <= '0;
    exp_n_in  <= '0;
    swap_m    <= 1'b1;   // reset value of cfg
    led_m     <= '0;
    exp_p_m   <= '0;
    exp_n_m   <= '0;
    idly_m    <= '0;
    err_exp   <= 1'b0;
    rd_chk    <= 1'b0;
    rd_exp    <= '0;
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge adc_clk);

    read_reg(`RP_ADDR_ID, 1'b0);
    read_reg(`RP_ADDR_CFG, 1'b0);

    // adc pairs every cycle, swap cleared half way through
    fork
      repeat (2 * ADC_PAIRS)
      begin
        @(posedge adc_clk);
        adc_dat_a <= adc_raw_t'($urandom);
        adc_dat_b <= adc_raw_t'($urandom);
      end
      begin
        repeat (ADC_PAIRS) @(posedge adc_clk);
        write_reg(`RP_ADDR_CFG, 32'h0, 1'b0);
      end
    join
    read_reg(`RP_ADDR_CFG, 1'b0);

    repeat (REG_ROUNDS)
    begin
      foreach (rw_addr[k])
        write_reg(rw_addr[k], $urandom, 1'b0);
      foreach (rw_addr[k])
        read_reg(rw_addr[k], 1'b0);
    end

    repeat (EXP_ROUNDS)
    begin
      @(posedge adc_clk);
      exp_p_in <= exp_bank_t'($urandom);
      exp_n_in <= exp_bank_t'($urandom);
      repeat (3) @(posedge adc_clk);   // two sync flops and one spare
      read_reg(`RP_ADDR_EXP_P_IN, 1'b0);
      read_reg(`RP_ADDR_EXP_N_IN, 1'b0);
    end

    // taps: load all, 40 up past 31, then down past 0 with a load in between
    write_reg(`RP_ADDR_IDLY_CTRL, 32'h0002_3FFF, 1'b0);
    for (int i = 0; i < TAP_STEPS; i++)
    begin
      mask = 14'($urandom) | ((i % 4 != 3) ? 14'h0081 : 14'h0000);
      v    = {14'b0, (i == 70), (i < 40), 2'b00, mask};
      write_reg(`RP_ADDR_IDLY_CTRL, v, 1'b0);
      read_reg(`RP_ADDR_IDLY_CNT, 1'b0);
    end
    read_reg(`RP_ADDR_IDLY_CTRL, 1'b0);

    read_reg(8'h20, 1'b1);                    // hole in the map
    write_reg(`RP_ADDR_ID, $urandom, 1'b1);   // read only
    read_reg(`RP_ADDR_ID, 1'b0);

    repeat (4) @(posedge adc_clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: verilog/rp_top.sv
// top level, adc capture path plus apb housekeeping on adc_clk
`timescale 1ns/10ps
`include "rp_cfg.svh"

module rp_top (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,     // async, active low
  // apb
  input  rp_pkg::apb_req_t            apb_req_i,
  output rp_pkg::apb_rsp_t            apb_rsp_o,
  // adc, two words per cycle
  input  rp_pkg::adc_raw_t            adc_dat_a_i,
  input  rp_pkg::adc_raw_t            adc_dat_b_i,
  output rp_pkg::adc_dat_t            adc_ch1_o,
  output rp_pkg::adc_dat_t            adc_ch2_o,
  // expansion connector, pads live outside
  input  rp_pkg::exp_bank_t           exp_p_i,
  input  rp_pkg::exp_bank_t           exp_n_i,
  output rp_pkg::exp_ctrl_t           exp_p_o,
  output rp_pkg::exp_ctrl_t           exp_n_o,
  // leds
  output logic [`RP_LED_BITS-1:0]     led_o
);

  import rp_pkg::*;

  logic      swap;                       // cfg bit 0
  idly_cmd_t idly_cmd;                   // tap command pulse
  idly_cnt_t idly_cnt_a;                 // lane 0, ch a
  idly_cnt_t idly_cnt_b;                 // lane 0, ch b
  exp_bank_t exp_p_sync;
  exp_bank_t exp_n_sync;

  //////////////////////////////
  // adc path
  //////////////////////////////

  adc_capture adc_capture_i (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .swap_i      (swap       ),
    .adc_ch1_o   (adc_ch1_o  ),
    .adc_ch2_o   (adc_ch2_o  )
  );

  //////////////////////////////
  // housekeeping
  //////////////////////////////

  hk_regs hk_regs_i (
    .adc_clk      (adc_clk   ),
    .rst_n_i      (rst_n_i   ),
    .apb_req_i    (apb_req_i ),
    .apb_rsp_o    (apb_rsp_o ),
    .exp_p_sync_i (exp_p_sync),
    .exp_n_sync_i (exp_n_sync),
    .idly_cnt_a_i (idly_cnt_a),
    .idly_cnt_b_i (idly_cnt_b),
    .swap_o       (swap      ),
    .led_o        (led_o     ),
    .exp_p_o      (exp_p_o   ),
    .exp_n_o      (exp_n_o   ),
    .idly_cmd_o   (idly_cmd  )
  );

  hk_idly hk_idly_i (
    .adc_clk      (adc_clk   ),
    .rst_n_i      (rst_n_i   ),
    .idly_cmd_i   (idly_cmd  ),
    .idly_cnt_a_o (idly_cnt_a),
    .idly_cnt_b_o (idly_cnt_b)
  );

  hk_exp_sync hk_exp_sync_i (
    .adc_clk      (adc_clk   ),
    .rst_n_i      (rst_n_i   ),
    .exp_p_i      (exp_p_i   ),
    .exp_n_i      (exp_n_i   ),
    .exp_p_sync_o (exp_p_sync),
    .exp_n_sync_o (exp_n_sync)
  );

endmodule

// File: hk/hk_regs.sv
// housekeeping register file, apb decode, writable regs, read mux and tap commands
`timescale 1ns/10ps
`include "rp_cfg.svh"

module hk_regs (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  // apb
  input  rp_pkg::apb_req_t        apb_req_i,
  output rp_pkg::apb_rsp_t        apb_rsp_o,
  // status in
  input  rp_pkg::exp_bank_t       exp_p_sync_i,   // already synchronized
  input  rp_pkg::exp_bank_t       exp_n_sync_i,
  input  rp_pkg::idly_cnt_t       idly_cnt_a_i,   // lane 0, ch a
  input  rp_pkg::idly_cnt_t       idly_cnt_b_i,   // lane 0, ch b
  // control out
  output logic                    swap_o,
  output logic [`RP_LED_BITS-1:0] led_o,
  output rp_pkg::exp_ctrl_t       exp_p_o,
  output rp_pkg::exp_ctrl_t       exp_n_o,
  output rp_pkg::idly_cmd_t       idly_cmd_o
);

  import rp_pkg::*;

  localparam int NL = 2 * `RP_ADC_LANES;   // all tap lanes

  logic                  acc;         // access phase
  logic                  wr_en;       // accepted write
  logic                  reg_hit;     // offset in map
  logic                  reg_ro;      // read only offset
  logic [`RP_APB_DW-1:0] reg_rdata;

  //////////////////////////////
  // decode
  //////////////////////////////

  assign acc   = apb_req_i.psel & apb_req_i.penable;
  assign wr_en = acc & apb_req_i.pwrite & reg_hit & ~reg_ro;   // bad writes dropped

  always_comb
  begin
    reg_hit   = 1'b1;
    reg_ro    = 1'b0;
    reg_rdata = '0;
    case (apb_req_i.paddr)
      `RP_ADDR_ID:
      begin
        reg_rdata = `RP_BLOCK_ID;
        reg_ro    = 1'b1;
      end
      `RP_ADDR_CFG:       reg_rdata[0] = swap_o;
      `RP_ADDR_EXP_P_DIR: reg_rdata[`RP_EXP_BITS-1:0] = exp_p_o.oe;
      `RP_ADDR_EXP_N_DIR: reg_rdata[`RP_EXP_BITS-1:0] = exp_n_o.oe;
      `RP_ADDR_EXP_P_OUT: reg_rdata[`RP_EXP_BITS-1:0] = exp_p_o.dat;
      `RP_ADDR_EXP_N_OUT: reg_rdata[`RP_EXP_BITS-1:0] = exp_n_o.dat;
      `RP_ADDR_EXP_P_IN:
      begin
        reg_rdata[`RP_EXP_BITS-1:0] = exp_p_sync_i;
        reg_ro                      = 1'b1;
      end
      `RP_ADDR_EXP_N_IN:
      begin
        reg_rdata[`RP_EXP_BITS-1:0] = exp_n_sync_i;
        reg_ro                      = 1'b1;
      end
      `RP_ADDR_LED:       reg_rdata[`RP_LED_BITS-1:0] = led_o;
      `RP_ADDR_IDLY_CTRL: reg_rdata = '0;   // command only, reads back 0
      `RP_ADDR_IDLY_CNT:
      begin
        reg_rdata[`RP_IDLY_BITS-1:0]   = idly_cnt_a_i;   // 4:0
        reg_rdata[8 +: `RP_IDLY_BITS]  = idly_cnt_b_i;   // 12:8
        reg_ro                         = 1'b1;
      end
      default:            reg_hit = 1'b0;
    endcase
  end

  //////////////////////////////
  // response, zero wait
  //////////////////////////////

  assign apb_rsp_o.prdata  = reg_rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = acc & (~reg_hit | (apb_req_i.pwrite & reg_ro));

  //////////////////////////////
  // writable registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      swap_o  <= 1'b1;   // boards come up swapped
      led_o   <= '0;
      exp_p_o <= '0;     // pins released
      exp_n_o <= '0;
    end
    else if (wr_en)
    begin
      case (apb_req_i.paddr)
        `RP_ADDR_CFG:       swap_o      <= apb_req_i.pwdata[0];
        `RP_ADDR_EXP_P_DIR: exp_p_o.oe  <= apb_req_i.pwdata[`RP_EXP_BITS-1:0];
        `RP_ADDR_EXP_N_DIR: exp_n_o.oe  <= apb_req_i.pwdata[`RP_EXP_BITS-1:0];
        `RP_ADDR_EXP_P_OUT: exp_p_o.dat <= apb_req_i.pwdata[`RP_EXP_BITS-1:0];
        `RP_ADDR_EXP_N_OUT: exp_n_o.dat <= apb_req_i.pwdata[`RP_EXP_BITS-1:0];
        `RP_ADDR_LED:       led_o       <= apb_req_i.pwdata[`RP_LED_BITS-1:0];
        default:            ;
      endcase
    end
  end

  //////////////////////////////
  // tap command pulse
  //////////////////////////////

  // lives only in the access cycle, counters step on the closing edge
  always_comb
  begin
    idly_cmd_o = '0;
    if (wr_en && (apb_req_i.paddr == `RP_ADDR_IDLY_CTRL))
    begin
      idly_cmd_o.mask = apb_req_i.pwdata[NL-1:0];   // 13:0
      idly_cmd_o.inc  = apb_req_i.pwdata[16];
      idly_cmd_o.load = apb_req_i.pwdata[17];
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // requester must go through setup before access
  a_apb_setup: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    apb_req_i.penable |-> $past(apb_req_i.psel && !apb_req_i.penable)
  );

  // counters see at most one step per transfer
  a_cmd_pulse: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (idly_cmd_o != '0) |=> (idly_cmd_o == '0)
  );

endmodule

// File: hk/hk_idly.sv
// input delay tap counters, fourteen wrapping 5 bit lanes driven by register commands
`timescale 1ns/10ps
`include "rp_cfg.svh"

module hk_idly (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::idly_cmd_t idly_cmd_i,     // zero when idle
  output rp_pkg::idly_cnt_t idly_cnt_a_o,   // lane 0, ch a
  output rp_pkg::idly_cnt_t idly_cnt_b_o    // lane 0, ch b
);

  import rp_pkg::*;

  localparam int NL = 2 * `RP_ADC_LANES;

  idly_cnt_t [NL-1:0] cnt_q;   // lanes 0..6 ch a, 7..13 ch b

  //////////////////////////////
  // counters
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else
    begin
      for (int i = 0; i < NL; i++)
      begin
        if (idly_cmd_i.mask[i])
        begin
          if (idly_cmd_i.load)
            cnt_q[i] <= '0;                 // back to tap 0
          else if (idly_cmd_i.inc)
            cnt_q[i] <= cnt_q[i] + 1'b1;    // 31 -> 0
          else
            cnt_q[i] <= cnt_q[i] - 1'b1;    // 0 -> 31
        end
      end
    end
  end

  // only lane 0 of each channel is visible in the map
  assign idly_cnt_a_o = cnt_q[0];
  assign idly_cnt_b_o = cnt_q[`RP_ADC_LANES];

  //////////////////////////////
  // checks
  //////////////////////////////

  a_hold_idle: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (idly_cmd_i.mask == '0) |=> $stable(cnt_q)
  );

endmodule

// File: hk/hk_exp_sync.sv
// expansion input synchronizer, two flops per pin for both banks
`timescale 1ns/10ps

module hk_exp_sync (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::exp_bank_t exp_p_i,        // async pins
  input  rp_pkg::exp_bank_t exp_n_i,
  output rp_pkg::exp_bank_t exp_p_sync_o,
  output rp_pkg::exp_bank_t exp_n_sync_o
);

  import rp_pkg::*;

  exp_bank_t p_meta, n_meta;   // first flop, may go metastable

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      p_meta       <= '0;
      n_meta       <= '0;
      exp_p_sync_o <= '0;
      exp_n_sync_o <= '0;
    end
    else
    begin
      p_meta       <= exp_p_i;
      n_meta       <= exp_n_i;
      exp_p_sync_o <= p_meta;   // settled after two edges
      exp_n_sync_o <= n_meta;
    end
  end

endmodule

// File: adc/adc_capture.sv
// adc capture, two stage sample register with channel swap and msb truncation
`timescale 1ns/10ps
`include "rp_cfg.svh"

module adc_capture (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::adc_raw_t adc_dat_a_i,   // channel a word
  input  rp_pkg::adc_raw_t adc_dat_b_i,   // channel b word
  input  logic             swap_i,        // 1 = b->ch1, a->ch2
  output rp_pkg::adc_dat_t adc_ch1_o,
  output rp_pkg::adc_dat_t adc_ch2_o
);

  import rp_pkg::*;

  localparam int MSB = `RP_ADC_RAW_BITS - 1;
  localparam int DW  = `RP_ADC_DATA_BITS;

  adc_raw_t dat_a_q;   // stage one
  adc_raw_t dat_b_q;
  adc_dat_t trunc_a;   // top bits only
  adc_dat_t trunc_b;

  //////////////////////////////
  // stage one, raw sample
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dat_a_q <= '0;
      dat_b_q <= '0;
    end
    else
    begin
      dat_a_q <= adc_dat_a_i;
      dat_b_q <= adc_dat_b_i;
    end
  end

  // drop the lsbs, same as the old loopback
  assign trunc_a = dat_a_q[MSB -: DW];
  assign trunc_b = dat_b_q[MSB -: DW];

  //////////////////////////////
  // stage two, order + output
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_ch1_o <= '0;
      adc_ch2_o <= '0;
    end
    else
    begin
      // swap is sampled here, so a cfg write hits the next pair entering
      adc_ch1_o <= swap_i ? trunc_b : trunc_a;
      adc_ch2_o <= swap_i ? trunc_a : trunc_b;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // x on the pins means an undriven converter word got through both stages
  a_no_x_out: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown({adc_ch1_o, adc_ch2_o})
  );

endmodule

// File: common/rp_pkg.sv
// shared types for the adc capture path and the apb housekeeping block
`include "rp_cfg.svh"

package rp_pkg;

  //////////////////////////////
  // plain vectors
  //////////////////////////////

  typedef logic [`RP_ADC_RAW_BITS-1:0]  adc_raw_t;   // raw converter word
  typedef logic [`RP_ADC_DATA_BITS-1:0] adc_dat_t;   // truncated sample
  typedef logic [`RP_IDLY_BITS-1:0]     idly_cnt_t;  // one tap count
  typedef logic [`RP_EXP_BITS-1:0]      exp_bank_t;  // one expansion bank

  //////////////////////////////
  // apb
  //////////////////////////////

  // requester side, 43 bits
  typedef struct packed {
    logic [`RP_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`RP_APB_DW-1:0] pwdata;
  } apb_req_t;

  // completer side, 34 bits
  typedef struct packed {
    logic [`RP_APB_DW-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  //////////////////////////////
  // housekeeping
  //////////////////////////////

  // one bank towards the pads
  typedef struct packed {
    exp_bank_t dat;   // output data
    exp_bank_t oe;    // 1 = drive pin
  } exp_ctrl_t;

  // tap command, single cycle, zero when idle
  typedef struct packed {
    logic                         load;   // clear masked lanes
    logic [2*`RP_ADC_LANES-1:0]   mask;   // lanes 0..6 ch a, 7..13 ch b
    logic                         inc;    // 1 up, 0 down
  } idly_cmd_t;

endpackage

// File: common/rp_cfg.svh
// fast adc path and housekeeping config, widths, register map and block id
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

//////////////////////////////
// adc data path
//////////////////////////////

`define RP_ADC_RAW_BITS   14     // converter word, already deserialized
`define RP_ADC_DATA_BITS  12     // kept msbs per channel
`define RP_ADC_LANES      7      // data lanes per channel

//////////////////////////////
// housekeeping
//////////////////////////////

`define RP_IDLY_BITS      5      // tap counter, wraps like the delay cell
`define RP_EXP_BITS       9      // one expansion bank
`define RP_LED_BITS       8
`define RP_APB_AW         8
`define RP_APB_DW         32

// byte offsets
`define RP_ADDR_ID        8'h00
`define RP_ADDR_CFG       8'h04
`define RP_ADDR_EXP_P_DIR 8'h08
`define RP_ADDR_EXP_N_DIR 8'h0C
`define RP_ADDR_EXP_P_OUT 8'h10
`define RP_ADDR_EXP_N_OUT 8'h14
`define RP_ADDR_EXP_P_IN  8'h18
`define RP_ADDR_EXP_N_IN  8'h1C
`define RP_ADDR_LED       8'h30
`define RP_ADDR_IDLY_CTRL 8'h34
`define RP_ADDR_IDLY_CNT  8'h38

`define RP_BLOCK_ID       32'h5250_0001   // read only, "RP" + rev 1

`endif
